// ==== src/wfm_cfg.svh ====
`ifndef WFM_CFG_SVH
`define WFM_CFG_SVH

// ----------------------------------------------------------------------
// ADC front end
// ----------------------------------------------------------------------
// number of ADC channels, one sample each per dsp_clk
`define WFM_N_CH      8
// bits per ADC sample
`define WFM_SAMPLE_W  16

// ----------------------------------------------------------------------
// capture buffer and bus map
// ----------------------------------------------------------------------
// buffer address width, 32 words
`define WFM_AW        5
// upper address halves of the two bus windows
`define WFM_SFR_BASE  16'h0010
`define WFM_BUF_BASE  16'h0020

`endif

// ==== src/wfm_pkg.sv ====
`default_nettype none

`include "wfm_cfg.svh"

package wfm_pkg;

    // cpu to responder, 69 bits
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
    } bus_fwd_t;

    // responder to cpu, all zeros when idle so returns can be OR-ed
    typedef struct packed {
        logic        ready;
        logic [31:0] rdata;
    } bus_ret_t;

    typedef logic [`WFM_SAMPLE_W-1:0] sample_t;

    // control word layout at the register address
    typedef struct packed {
        logic [7:0]  spare;
        logic [15:0] wfm_len;
        logic        trig;
        logic [2:0]  reserved;
        logic [3:0]  chan;
    } wfm_ctrl_t;

endpackage

`default_nettype wire

// ==== src/wfm_ctrl_reg.sv ====
`default_nettype none

`include "wfm_cfg.svh"

module wfm_ctrl_reg (
    input  wire logic         clk,
    input  wire logic         rst_n,
    input  wire wfm_pkg::bus_fwd_t bus_fwd,
    output wfm_pkg::bus_ret_t bus_ret,
    output wfm_pkg::wfm_ctrl_t ctrl,
    output logic              trig_pulse
);

    logic hit;
    logic wr_req;
    logic rd_req;
    logic ready_q;
    logic trig_q;

    // ------------------------------------------------------------------
    // address decode
    // ------------------------------------------------------------------
    assign hit    = bus_fwd.valid && (bus_fwd.addr[31:16] == `WFM_SFR_BASE);
    // only full-word writes act, partial strobes get no response
    assign wr_req = hit && (&bus_fwd.wstrb);
    assign rd_req = hit && (bus_fwd.wstrb == 4'b0000);

    // ------------------------------------------------------------------
    // register and handshake
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ready_q <= 1'b0;
            ctrl    <= '0;
            trig_q  <= 1'b0;
        end else begin
            // one ready per request, master drops valid afterwards
            ready_q <= (wr_req || rd_req) && !ready_q;
            trig_q  <= ctrl.trig;
            if (wr_req && !ready_q) begin
                ctrl <= wfm_pkg::wfm_ctrl_t'(bus_fwd.wdata);
            end
        end
    end

    // rising edge of trig only
    assign trig_pulse = ctrl.trig & ~trig_q;

    // read-back, zeros outside the response cycle
    always_comb begin
        bus_ret = '0;
        if (ready_q) begin
            bus_ret.ready = 1'b1;
            bus_ret.rdata = ctrl;
        end
    end

endmodule

`default_nettype wire

// ==== src/wfm_trig_sync.sv ====
`default_nettype none

module wfm_trig_sync (
    input  wire logic clk,
    input  wire logic dsp_clk,
    input  wire logic rst_n,
    input  wire logic trig_pulse,
    output logic      start
);

    // clk side
    logic req;
    logic ack_meta;
    logic ack_sync;

    // dsp_clk side
    logic req_meta;
    logic req_sync;
    logic req_sync_q;
    logic ack;

    // ------------------------------------------------------------------
    // request side, clk domain
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req      <= 1'b0;
            ack_meta <= 1'b0;
            ack_sync <= 1'b0;
        end else begin
            ack_meta <= ack;
            ack_sync <= ack_meta;
            // idle means req low and the returned ack already gone
            if (!req && !ack_sync && trig_pulse) begin
                req <= 1'b1;
            end else if (req && ack_sync) begin
                req <= 1'b0;
            end
        end
    end

    // ------------------------------------------------------------------
    // acknowledge side, dsp_clk domain
    // ------------------------------------------------------------------
    always_ff @(posedge dsp_clk) begin
        if (!rst_n) begin
            req_meta   <= 1'b0;
            req_sync   <= 1'b0;
            req_sync_q <= 1'b0;
        end else begin
            req_meta   <= req;
            req_sync   <= req_meta;
            req_sync_q <= req_sync;
        end
    end

    // synchronized req goes straight back as ack
    assign ack   = req_sync;
    assign start = req_sync & ~req_sync_q;

endmodule

`default_nettype wire

// ==== src/wfm_capture_seq.sv ====
`default_nettype none

`include "wfm_cfg.svh"

module wfm_capture_seq (
    input  wire logic                    dsp_clk,
    input  wire logic                    rst_n,
    input  wire logic                    start,
    input  wire wfm_pkg::wfm_ctrl_t      ctrl,
    input  wire wfm_pkg::sample_t [`WFM_N_CH-1:0] adc_data,
    output logic                         wr_en,
    output logic [`WFM_AW-1:0]           wr_addr,
    output wfm_pkg::sample_t             wr_data
);

    localparam int AW    = `WFM_AW;
    localparam int DEPTH = 1 << AW;
    localparam int CH_W  = $clog2(`WFM_N_CH);

    logic [15:0]   len_q;
    logic [CH_W-1:0] chan_q;
    logic [AW:0]   len_clip;
    logic [AW-1:0] left;

    // length clipped to the buffer depth
    assign len_clip = (len_q > DEPTH) ? (AW + 1)'(DEPTH) : len_q[AW:0];

    always_ff @(posedge dsp_clk) begin
        if (!rst_n) begin
            len_q   <= '0;
            chan_q  <= '0;
            wr_en   <= 1'b0;
            wr_addr <= '0;
            left    <= '0;
        end else begin
            // control is static while a capture runs
            len_q  <= ctrl.wfm_len;
            chan_q <= ctrl.chan[CH_W-1:0];
            if (!wr_en) begin
                if (start && (len_clip != '0)) begin
                    wr_en   <= 1'b1;
                    wr_addr <= '0;
                    left    <= AW'(len_clip - 1'b1);
                end
            end else begin
                // a start while writing is ignored
                wr_addr <= wr_addr + 1'b1;
                if (left == '0) begin
                    wr_en <= 1'b0;
                end else begin
                    left <= left - 1'b1;
                end
            end
        end
    end

    // sample of the current cycle goes to the current address
    assign wr_data = adc_data[chan_q];

endmodule

`default_nettype wire

// ==== src/wfm_sample_ram.sv ====
`default_nettype none

`include "wfm_cfg.svh"

module wfm_sample_ram (
    input  wire logic                dsp_clk,
    input  wire logic                wr_en,
    input  wire logic [`WFM_AW-1:0]  wr_addr,
    input  wire wfm_pkg::sample_t    wr_data,
    input  wire logic                clk,
    input  wire logic [`WFM_AW-1:0]  rd_addr,
    output wfm_pkg::sample_t         rd_data
);

    localparam int DEPTH = 1 << `WFM_AW;

    wfm_pkg::sample_t mem [0:DEPTH-1];

    // write port, adc side
    always_ff @(posedge dsp_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read port, bus side, one cycle latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== src/wfm_capture.sv ====
`default_nettype none

`include "wfm_cfg.svh"

module wfm_capture (
    input  wire logic                    clk,
    input  wire logic                    dsp_clk,
    input  wire logic                    rst_n,
    input  wire wfm_pkg::sample_t [`WFM_N_CH-1:0] adc_data,
    input  wire wfm_pkg::bus_fwd_t       bus_fwd,
    output wfm_pkg::bus_ret_t            bus_ret
);

    wfm_pkg::bus_ret_t  reg_ret;
    wfm_pkg::bus_ret_t  buf_ret;
    wfm_pkg::wfm_ctrl_t ctrl;
    logic               trig_pulse;
    logic               start;

    logic                wr_en;
    logic [`WFM_AW-1:0]  wr_addr;
    wfm_pkg::sample_t    wr_data;
    logic [`WFM_AW-1:0]  rd_addr;
    wfm_pkg::sample_t    rd_data;

    logic buf_rd;
    logic buf_ready;

    // ------------------------------------------------------------------
    // bus side, control register and trigger crossing
    // ------------------------------------------------------------------
    wfm_ctrl_reg u_ctrl_reg (
        .clk        (clk),
        .rst_n      (rst_n),
        .bus_fwd    (bus_fwd),
        .bus_ret    (reg_ret),
        .ctrl       (ctrl),
        .trig_pulse (trig_pulse)
    );

    wfm_trig_sync u_trig_sync (
        .clk        (clk),
        .dsp_clk    (dsp_clk),
        .rst_n      (rst_n),
        .trig_pulse (trig_pulse),
        .start      (start)
    );

    // ------------------------------------------------------------------
    // adc side, sequencer and buffer
    // ------------------------------------------------------------------
    wfm_capture_seq u_seq (
        .dsp_clk  (dsp_clk),
        .rst_n    (rst_n),
        .start    (start),
        .ctrl     (ctrl),
        .adc_data (adc_data),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    wfm_sample_ram u_ram (
        .dsp_clk (dsp_clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .clk     (clk),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    // ------------------------------------------------------------------
    // buffer read responder
    // ------------------------------------------------------------------
    // read only window, writes here are not answered
    assign buf_rd  = bus_fwd.valid && (bus_fwd.addr[31:16] == `WFM_BUF_BASE)
                     && (bus_fwd.wstrb == 4'b0000);
    assign rd_addr = bus_fwd.addr[2 +: `WFM_AW];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            buf_ready <= 1'b0;
        end else begin
            buf_ready <= buf_rd && !buf_ready;
        end
    end

    // ram output lines up with ready
    always_comb begin
        buf_ret = '0;
        if (buf_ready) begin
            buf_ret.ready = 1'b1;
            buf_ret.rdata = {{(32 - `WFM_SAMPLE_W){1'b0}}, rd_data};
        end
    end

    assign bus_ret = wfm_pkg::bus_ret_t'(reg_ret | buf_ret);

endmodule

`default_nettype wire

// ==== verification/wfm_capture_tb.sv ====
`default_nettype none

`include "wfm_cfg.svh"

module wfm_capture_tb;

    localparam int CH_W = $clog2(`WFM_N_CH);
    localparam int DEPTH = 1 << `WFM_AW;
    localparam int BUS_TIMEOUT = 50;
    localparam int POLL_LIMIT = 60;
    localparam logic [31:0] SFR_ADDR = {`WFM_SFR_BASE, 16'h0000};

    typedef struct {
        string name;
        int    chan;
        int    len;
        int    expect_words;
        bit    rearm;
    } row_t;

    logic                                 clk;
    logic                                 dsp_clk;
    logic                                 rst_n;
    wfm_pkg::sample_t [`WFM_N_CH-1:0]     adc_data;
    wfm_pkg::bus_fwd_t                    bus_fwd;
    wfm_pkg::bus_ret_t                    bus_ret;

    logic [11:0]       dsp_cnt;
    wfm_pkg::sample_t  shadow [0:DEPTH-1];
    row_t              rows [0:6];
    int                errors;
    integer            seed;

    wfm_capture dut (
        .clk      (clk),
        .dsp_clk  (dsp_clk),
        .rst_n    (rst_n),
        .adc_data (adc_data),
        .bus_fwd  (bus_fwd),
        .bus_ret  (bus_ret)
    );

    always #2 clk = ~clk;
    always #3 dsp_clk = ~dsp_clk;

    // ADC model with the channel number on top and a free-running dsp count below
    always @(posedge dsp_clk) begin
        #1;
        dsp_cnt = dsp_cnt + 1'b1;
        for (int c = 0; c < `WFM_N_CH; c++) begin
            adc_data[CH_W'(c)] = {4'(c), dsp_cnt};
        end
    end

    // ------------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------------
    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        if (act !== exp) begin
            errors++;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_sample(input string name, input wfm_pkg::sample_t exp,
                                input wfm_pkg::sample_t act);
        if (act !== exp) begin
            errors++;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // ------------------------------------------------------------------
    // bus tasks
    // ------------------------------------------------------------------
    // single request that drops valid after ready or after the timeout
    task automatic bus_xfer(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb, output logic got_ready,
                            output logic [31:0] rdata);
        int cyc;
        got_ready = 1'b0;
        rdata = '0;
        @(posedge clk);
        #1;
        bus_fwd.valid = 1'b1;
        bus_fwd.addr = addr;
        bus_fwd.wdata = wdata;
        bus_fwd.wstrb = wstrb;
        for (cyc = 0; cyc < BUS_TIMEOUT && !got_ready; cyc++) begin
            @(posedge clk);
            #1;
            if (bus_ret.ready) begin
                got_ready = 1'b1;
                rdata = bus_ret.rdata;
            end
        end
        bus_fwd = '0;
        // idle cycle between requests
        @(posedge clk);
        #1;
    endtask

    task automatic bus_write(input string name, input logic [31:0] addr,
                             input logic [31:0] data);
        logic        ok;
        logic [31:0] unused;
        bus_xfer(addr, data, 4'b1111, ok, unused);
        if (!ok) begin
            errors++;
            $display("%s: write to %h was never answered with ready", name, addr);
        end
    endtask

    task automatic bus_read(input string name, input logic [31:0] addr,
                            output logic [31:0] data);
        logic ok;
        bus_xfer(addr, 32'h0, 4'b0000, ok, data);
        if (!ok) begin
            errors++;
            $display("%s: read from %h was never answered with ready", name, addr);
        end
    endtask

    function automatic logic [31:0] buf_addr(input int k);
        return {`WFM_BUF_BASE, 16'(k * 4)};
    endfunction

    function automatic logic [31:0] ctrl_word(input int chan, input int len,
                                             input logic trig);
        wfm_pkg::wfm_ctrl_t cw;
        cw = '0;
        cw.chan = 4'(chan);
        cw.wfm_len = 16'(len);
        cw.trig = trig;
        return cw;
    endfunction

    // ------------------------------------------------------------------
    // capture helpers
    // ------------------------------------------------------------------
    // poll one buffer word until it moves away from its old value
    task automatic wait_capture(input string name, input int addr,
                                input wfm_pkg::sample_t old, output logic changed);
        int          n;
        logic [31:0] word;
        changed = 1'b0;
        for (n = 0; n < POLL_LIMIT && !changed; n++) begin
            bus_read(name, buf_addr(addr), word);
            if (word[15:0] !== old) begin
                changed = 1'b1;
            end
        end
    endtask

    task automatic run_row(input row_t r);
        logic             changed;
        logic [31:0]      word;
        wfm_pkg::sample_t first;
        wfm_pkg::sample_t exp;
        int               last;
        int               k;
        last = (r.expect_words > 0) ? r.expect_words - 1 : 0;
        first = '0;
        if (r.rearm) begin
            bus_write(r.name, SFR_ADDR, ctrl_word(r.chan, r.len, 1'b0));
        end
        bus_write(r.name, SFR_ADDR, ctrl_word(r.chan, r.len, 1'b1));
        wait_capture(r.name, last, shadow[`WFM_AW'(last)], changed);
        if (changed != (r.expect_words > 0)) begin
            errors++;
            $display("%s: buffer word %0d %s after the trigger", r.name, last,
                     changed ? "changed" : "did not change");
        end
        for (k = 0; k < DEPTH; k++) begin
            bus_read(r.name, buf_addr(k), word);
            // upper half of a buffer word is always zero
            check_word(r.name, 32'h0000_0000, word & 32'hffff_0000);
            if (k < r.expect_words) begin
                if (k == 0) begin
                    first = word[15:0];
                end
                exp = {4'(r.chan), 12'(first[11:0] + k)};
                check_sample(r.name, exp, word[15:0]);
            end else begin
                check_sample(r.name, shadow[`WFM_AW'(k)], word[15:0]);
            end
            shadow[`WFM_AW'(k)] = word[15:0];
        end
    endtask

    // ------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------
    initial begin
        logic [31:0] word;
        logic        ok;
        int          prev_chan;
        clk = 1'b0;
        dsp_clk = 1'b0;
        rst_n = 1'b0;
        adc_data = '0;
        bus_fwd = '0;
        dsp_cnt = '0;
        errors = 0;
        seed = 32'hf025;
        prev_chan = -1;

        rows[0] = '{"full32", 0, 32, 32, 1'b1};
        rows[1] = '{"short5", 0, 5, 5, 1'b1};
        rows[2] = '{"len40", 0, 40, 32, 1'b1};
        rows[3] = '{"len0", 0, 0, 0, 1'b1};
        rows[4] = '{"len17", 0, 17, 17, 1'b1};
        rows[5] = '{"trig_held", 0, 32, 0, 1'b0};
        rows[6] = '{"trig_rearm", 0, 32, 32, 1'b1};

        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // register read after reset and after full and partial writes
        bus_read("reg_reset", SFR_ADDR, word);
        check_word("reg_reset", 32'h0000_0000, word);
        bus_write("reg_write", SFR_ADDR, 32'h5a12_3473);
        bus_read("reg_write", SFR_ADDR, word);
        check_word("reg_write", 32'h5a12_3473, word);
        bus_xfer(SFR_ADDR, 32'hffff_ffff, 4'b0011, ok, word);
        if (ok) begin
            errors++;
            $display("reg_partial: a partial-strobe write was answered with ready");
        end
        bus_read("reg_partial", SFR_ADDR, word);
        check_word("reg_partial", 32'h5a12_3473, word);

        // capture table with each row on a channel other than the previous one
        for (int i = 0; i < 7; i++) begin
            rows[3'(i)].chan = int'($unsigned($random(seed)) % `WFM_N_CH);
            if (rows[3'(i)].chan == prev_chan) begin
                rows[3'(i)].chan = (prev_chan + 1) % `WFM_N_CH;
            end
            prev_chan = rows[3'(i)].chan;
            run_row(rows[3'(i)]);
        end

        // nothing lives at this window
        bus_xfer({16'h0030, 16'h0000}, 32'h0, 4'b0000, ok, word);
        if (ok) begin
            errors++;
            $display("unmapped: a read at an unmapped address got ready");
        end

        $display("checks done, %0d errors", errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+src
src/wfm_pkg.sv
src/wfm_ctrl_reg.sv
src/wfm_trig_sync.sv
src/wfm_capture_seq.sv
src/wfm_sample_ram.sv
src/wfm_capture.sv
verification/wfm_capture_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= wfm_capture_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SRCS := $(shell grep -v '^+' $(FILELIST)) src/wfm_cfg.svh
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)

check: run
	@if grep -q "Verification failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Verification passed" $(LOG) || (echo "no result found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
